// File: Bender.yml
package:
  name: shim_hw_manager

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/shim_pkg.sv
      - hdl/shim_fault_arbiter.sv
      - hdl/shim_power_sequencer.sv
      - hdl/shim_hw_manager.sv
  - target: test
    files:
      - tb/shim_hw_manager_tb.sv

// File: hdl/shim_consts.svh
`ifndef SHIM_CONSTS_SVH
`define SHIM_CONSTS_SVH

// Board fan-out
`define SHIM_NUM_BOARDS 8 // Amplifier boards per system
`define SHIM_BOARD_W 3    // Board number width

// Status word field widths
`define SHIM_CODE_W 25 // Status code
`define SHIM_STATE_W 4 // FSM state

// Minimum cycles in CONFIRM_SPI_RST before spi_off is trusted
`define SHIM_SPI_RST_CHECK 32'd10

// Default delays at a 100 MHz clock
`define SHIM_DEF_FORCE_DELAY 32'd10_000_000     // 100 ms from force release to SPI start
`define SHIM_DEF_RST_PULSE 32'd10_000           // 100 us shutdown reset pulse
`define SHIM_DEF_RST_DELAY 32'd10_000_000       // 100 ms from reset pulse to RUNNING
`define SHIM_DEF_SPI_RST_WAIT 32'd100_000_000   // 1 s for SPI off confirmation
`define SHIM_DEF_SPI_START_WAIT 32'd100_000_000 // 1 s for SPI subsystem start

`endif

// File: hdl/shim_fault_arbiter.sv
`timescale 1ns/10ps

module shim_fault_arbiter (
  input  logic                        sys_en,
  input  logic                        lock_viol,
  input  logic                        ext_shutdown,
  input  shim_pkg::shim_cfg_flags_t   cfg,
  input  shim_pkg::shim_boot_flags_t  boot,
  input  shim_pkg::shim_board_flags_t board,
  output logic                        cfg_fault,
  output shim_pkg::shim_status_t      cfg_status,
  output logic                        boot_fault,
  output shim_pkg::shim_status_t      boot_status,
  output logic                        run_fault,
  output shim_pkg::shim_status_t      run_status
);

  // Any flag at all per phase
  assign cfg_fault  = |cfg;
  assign boot_fault = |boot;
  assign run_fault  = !sys_en || lock_viol || ext_shutdown || (|board);

  // Pre-start range checks, never board specific
  always_comb begin
    cfg_status.board_num = '0;
    if (cfg.integ_thresh_avg_oob) begin
      cfg_status.code = shim_pkg::INTEG_THRESH_AVG_OOB;
    end else if (cfg.integ_window_oob) begin
      cfg_status.code = shim_pkg::INTEG_WINDOW_OOB;
    end else if (cfg.integ_en_oob) begin
      cfg_status.code = shim_pkg::INTEG_EN_OOB;
    end else if (cfg.sys_en_oob) begin
      cfg_status.code = shim_pkg::SYS_EN_OOB;
    end else begin
      cfg_status.code = shim_pkg::OK; // Don't care, cfg_fault low
    end
  end

  // Boot failures during SPI start
  always_comb begin
    boot_status.board_num = '0;
    boot_status.code      = shim_pkg::OK;
    if (|boot.dac_boot_fail) begin // DAC side first
      boot_status.code      = shim_pkg::DAC_BOOT_FAIL;
      boot_status.board_num = shim_pkg::first_board(boot.dac_boot_fail);
    end else if (|boot.adc_boot_fail) begin
      boot_status.code      = shim_pkg::ADC_BOOT_FAIL;
      boot_status.board_num = shim_pkg::first_board(boot.adc_boot_fail);
    end
  end

  // Running faults, single-bit sources report board 0
  always_comb begin
    run_status.board_num = '0;
    run_status.code      = shim_pkg::OK;
    if (!sys_en) begin
      run_status.code = shim_pkg::PS_SHUTDOWN; // Orderly shutdown request
    end else if (lock_viol) begin
      run_status.code = shim_pkg::LOCK_VIOL;
    end else if (|board.shutdown_sense) begin
      run_status.code      = shim_pkg::SHUTDOWN_SENSE;
      run_status.board_num = shim_pkg::first_board(board.shutdown_sense);
    end else if (ext_shutdown) begin
      run_status.code = shim_pkg::EXT_SHUTDOWN;
    end else if (|board.over_thresh) begin
      // Integrator threshold core
      run_status.code      = shim_pkg::OVER_THRESH;
      run_status.board_num = shim_pkg::first_board(board.over_thresh);
    end else if (|board.thresh_underflow) begin
      run_status.code      = shim_pkg::THRESH_UNDERFLOW;
      run_status.board_num = shim_pkg::first_board(board.thresh_underflow);
    end else if (|board.thresh_overflow) begin
      run_status.code      = shim_pkg::THRESH_OVERFLOW;
      run_status.board_num = shim_pkg::first_board(board.thresh_overflow);
    end else if (|board.bad_dac_cmd) begin
      // DAC command path
      run_status.code      = shim_pkg::BAD_DAC_CMD;
      run_status.board_num = shim_pkg::first_board(board.bad_dac_cmd);
    end else if (|board.dac_cmd_buf_underflow) begin
      run_status.code      = shim_pkg::DAC_BUF_UNDERFLOW;
      run_status.board_num = shim_pkg::first_board(board.dac_cmd_buf_underflow);
    end else if (|board.dac_cmd_buf_overflow) begin
      run_status.code      = shim_pkg::DAC_BUF_OVERFLOW;
      run_status.board_num = shim_pkg::first_board(board.dac_cmd_buf_overflow);
    end else if (|board.bad_adc_cmd) begin
      // ADC command path
      run_status.code      = shim_pkg::BAD_ADC_CMD;
      run_status.board_num = shim_pkg::first_board(board.bad_adc_cmd);
    end else if (|board.adc_cmd_buf_underflow) begin
      run_status.code      = shim_pkg::ADC_CMD_BUF_UNDERFLOW;
      run_status.board_num = shim_pkg::first_board(board.adc_cmd_buf_underflow);
    end else if (|board.adc_cmd_buf_overflow) begin
      run_status.code      = shim_pkg::ADC_CMD_BUF_OVERFLOW;
      run_status.board_num = shim_pkg::first_board(board.adc_cmd_buf_overflow);
    end
  end

endmodule

// File: hdl/shim_hw_manager.sv
`timescale 1ns/10ps

`include "shim_consts.svh"

module shim_hw_manager #(
  parameter logic [31:0] FORCE_DELAY    = `SHIM_DEF_FORCE_DELAY,
  parameter logic [31:0] RST_PULSE      = `SHIM_DEF_RST_PULSE,
  parameter logic [31:0] RST_DELAY      = `SHIM_DEF_RST_DELAY,
  parameter logic [31:0] SPI_RST_WAIT   = `SHIM_DEF_SPI_RST_WAIT,
  parameter logic [31:0] SPI_START_WAIT = `SHIM_DEF_SPI_START_WAIT
) (
  input  logic                        clk,
  input  logic                        aresetn,
  input  logic                        sys_en,       // Power the system up
  input  logic                        spi_off,      // SPI subsystem idle
  input  logic                        lock_viol,    // Write to locked config
  input  logic                        ext_shutdown,
  input  shim_pkg::shim_cfg_flags_t   cfg,
  input  shim_pkg::shim_boot_flags_t  boot,
  input  shim_pkg::shim_board_flags_t board,
  output shim_pkg::shim_ctrl_t        ctrl,
  output logic [31:0]                 status_word,  // {board_num, code, state}
  output logic                        ps_interrupt
);

  // Fault candidates per phase
  logic                   cfg_fault;
  logic                   boot_fault;
  logic                   run_fault;
  shim_pkg::shim_status_t cfg_status;
  shim_pkg::shim_status_t boot_status;
  shim_pkg::shim_status_t run_status;

  shim_pkg::shim_state_e  state;
  shim_pkg::shim_status_t status;

  shim_fault_arbiter i_fault_arbiter (
    .sys_en       (sys_en),
    .lock_viol    (lock_viol),
    .ext_shutdown (ext_shutdown),
    .cfg          (cfg),
    .boot         (boot),
    .board        (board),
    .cfg_fault    (cfg_fault),
    .cfg_status   (cfg_status),
    .boot_fault   (boot_fault),
    .boot_status  (boot_status),
    .run_fault    (run_fault),
    .run_status   (run_status)
  );

  shim_power_sequencer #(
    .FORCE_DELAY    (FORCE_DELAY),
    .RST_PULSE      (RST_PULSE),
    .RST_DELAY      (RST_DELAY),
    .SPI_RST_WAIT   (SPI_RST_WAIT),
    .SPI_START_WAIT (SPI_START_WAIT)
  ) i_power_sequencer (
    .clk          (clk),
    .aresetn      (aresetn),
    .sys_en       (sys_en),
    .spi_off      (spi_off),
    .cfg_fault    (cfg_fault),
    .cfg_status   (cfg_status),
    .boot_fault   (boot_fault),
    .boot_status  (boot_status),
    .run_fault    (run_fault),
    .run_status   (run_status),
    .ctrl         (ctrl),
    .state        (state),
    .status       (status),
    .ps_interrupt (ps_interrupt)
  );

  // Board number lands in 31:29, code in 28:4
  assign status_word = {status, state};

endmodule

// File: hdl/shim_pkg.sv
`include "shim_consts.svh"

package shim_pkg;

  // Sequencer states, visible in status_word[3:0]
  typedef enum logic [`SHIM_STATE_W-1:0] {
    IDLE              = 'd1, // Powered down, waiting for sys_en
    CONFIRM_SPI_RST   = 'd2,
    POWER_ON_CTRL_BRD = 'd3,
    CONFIRM_SPI_START = 'd4,
    POWER_ON_AMP_BRD  = 'd5, // Shutdown reset pulse
    AMP_POWER_WAIT    = 'd6,
    RUNNING           = 'd7,
    HALTING           = 'd8, // Single cycle
    HALTED            = 'd9  // Waits for sys_en low
  } shim_state_e;

  // Status codes, upper nibble groups the source
  typedef enum logic [`SHIM_CODE_W-1:0] {
    EMPTY                 = 'h000,
    OK                    = 'h001,
    PS_SHUTDOWN           = 'h002, // sys_en dropped while running
    SPI_RESET_TIMEOUT     = 'h100,
    SPI_START_TIMEOUT     = 'h101,
    INTEG_THRESH_AVG_OOB  = 'h200,
    INTEG_WINDOW_OOB      = 'h201,
    INTEG_EN_OOB          = 'h202,
    SYS_EN_OOB            = 'h203,
    LOCK_VIOL             = 'h204,
    SHUTDOWN_SENSE        = 'h300,
    EXT_SHUTDOWN          = 'h301,
    OVER_THRESH           = 'h400,
    THRESH_UNDERFLOW      = 'h401,
    THRESH_OVERFLOW       = 'h402,
    DAC_BOOT_FAIL         = 'h600,
    BAD_DAC_CMD           = 'h601,
    DAC_BUF_UNDERFLOW     = 'h604,
    DAC_BUF_OVERFLOW      = 'h605,
    ADC_BOOT_FAIL         = 'h700,
    BAD_ADC_CMD           = 'h701,
    ADC_CMD_BUF_UNDERFLOW = 'h702,
    ADC_CMD_BUF_OVERFLOW  = 'h703
  } shim_code_e;

  // Board number on top so {status, state} forms the status word
  typedef struct packed {
    logic [`SHIM_BOARD_W-1:0] board_num;
    shim_code_e               code;
  } shim_status_t;

  // Pre-start range checks, highest priority first
  typedef struct packed {
    logic integ_thresh_avg_oob;
    logic integ_window_oob;
    logic integ_en_oob;
    logic sys_en_oob;
  } shim_cfg_flags_t;

  // Per-board running faults, highest priority first
  typedef struct packed {
    logic [`SHIM_NUM_BOARDS-1:0] shutdown_sense;
    logic [`SHIM_NUM_BOARDS-1:0] over_thresh;      // Integrator threshold core
    logic [`SHIM_NUM_BOARDS-1:0] thresh_underflow;
    logic [`SHIM_NUM_BOARDS-1:0] thresh_overflow;
    logic [`SHIM_NUM_BOARDS-1:0] bad_dac_cmd;
    logic [`SHIM_NUM_BOARDS-1:0] dac_cmd_buf_underflow;
    logic [`SHIM_NUM_BOARDS-1:0] dac_cmd_buf_overflow;
    logic [`SHIM_NUM_BOARDS-1:0] bad_adc_cmd;
    logic [`SHIM_NUM_BOARDS-1:0] adc_cmd_buf_underflow;
    logic [`SHIM_NUM_BOARDS-1:0] adc_cmd_buf_overflow;
  } shim_board_flags_t;

  // Boot failures, DAC wins over ADC
  typedef struct packed {
    logic [`SHIM_NUM_BOARDS-1:0] dac_boot_fail;
    logic [`SHIM_NUM_BOARDS-1:0] adc_boot_fail;
  } shim_boot_flags_t;

  // Power and SPI control levels
  typedef struct packed {
    logic unlock_cfg;        // Config registers writable
    logic spi_clk_gate;      // SPI clock power
    logic spi_en;
    logic shutdown_sense_en;
    logic block_buffers;     // Holds PL side of cmd/data buffers
    logic n_shutdown_force;  // Active low
    logic n_shutdown_rst;    // Active low
  } shim_ctrl_t;

  // Lowest set board, 0 when none set
  function automatic logic [`SHIM_BOARD_W-1:0] first_board(
    input logic [`SHIM_NUM_BOARDS-1:0] vec
  );
    logic [`SHIM_BOARD_W-1:0] idx;
    idx = '0;
    for (int i = `SHIM_NUM_BOARDS - 1; i >= 0; i--) begin
      if (vec[i]) idx = i[`SHIM_BOARD_W-1:0]; // Last hit is the lowest
    end
    return idx;
  endfunction

endpackage

// File: hdl/shim_power_sequencer.sv
`timescale 1ns/10ps

`include "shim_consts.svh"

module shim_power_sequencer #(
  parameter logic [31:0] FORCE_DELAY    = `SHIM_DEF_FORCE_DELAY,   // Force release to SPI start
  parameter logic [31:0] RST_PULSE      = `SHIM_DEF_RST_PULSE,     // Shutdown reset pulse width
  parameter logic [31:0] RST_DELAY      = `SHIM_DEF_RST_DELAY,     // Reset pulse to RUNNING
  parameter logic [31:0] SPI_RST_WAIT   = `SHIM_DEF_SPI_RST_WAIT,  // SPI off timeout
  parameter logic [31:0] SPI_START_WAIT = `SHIM_DEF_SPI_START_WAIT // SPI start timeout
) (
  input  logic                   clk,
  input  logic                   aresetn,
  input  logic                   sys_en,
  input  logic                   spi_off,
  input  logic                   cfg_fault,
  input  shim_pkg::shim_status_t cfg_status,
  input  logic                   boot_fault,
  input  shim_pkg::shim_status_t boot_status,
  input  logic                   run_fault,
  input  shim_pkg::shim_status_t run_status,
  output shim_pkg::shim_ctrl_t   ctrl,
  output shim_pkg::shim_state_e  state,
  output shim_pkg::shim_status_t status,
  output logic                   ps_interrupt
);

  // Safe control levels, hardware off and config open
  localparam shim_pkg::shim_ctrl_t CTRL_OFF = '{
    unlock_cfg:        1'b1,
    spi_clk_gate:      1'b0,
    spi_en:            1'b0,
    shutdown_sense_en: 1'b0,
    block_buffers:     1'b1,
    n_shutdown_force:  1'b0,
    n_shutdown_rst:    1'b1
  };

  localparam shim_pkg::shim_status_t STATUS_OK = '{board_num: '0, code: shim_pkg::OK};

  logic [31:0] timer; // Shared by all wait and timeout states

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state        <= shim_pkg::IDLE;
      timer        <= '0;
      ctrl         <= CTRL_OFF;
      status       <= STATUS_OK;
      ps_interrupt <= 1'b0;
    end else begin
      case (state)
        shim_pkg::IDLE: begin
          if (sys_en) begin
            if (cfg_fault) begin // Bad range, skip power-up
              state  <= shim_pkg::HALTING;
              status <= cfg_status;
            end else begin
              state           <= shim_pkg::CONFIRM_SPI_RST;
              timer           <= '0;
              ctrl.unlock_cfg <= 1'b0; // Lock config for the run
            end
          end
        end

        // SPI subsystem has to report off before power is applied
        shim_pkg::CONFIRM_SPI_RST: begin
          if (timer >= `SHIM_SPI_RST_CHECK && spi_off) begin
            state                 <= shim_pkg::POWER_ON_CTRL_BRD;
            timer                 <= '0;
            ctrl.n_shutdown_force <= 1'b1; // Release shutdown force
          end else if (timer >= SPI_RST_WAIT) begin
            state  <= shim_pkg::HALTING;
            status <= '{board_num: '0, code: shim_pkg::SPI_RESET_TIMEOUT};
          end else begin
            timer <= timer + 32'd1;
          end
        end

        // Let the control board settle before SPI traffic
        shim_pkg::POWER_ON_CTRL_BRD: begin
          if (timer >= FORCE_DELAY) begin
            state                  <= shim_pkg::CONFIRM_SPI_START;
            timer                  <= '0;
            ctrl.spi_clk_gate      <= 1'b1;
            ctrl.spi_en            <= 1'b1;
            ctrl.shutdown_sense_en <= 1'b1;
          end else begin
            timer <= timer + 32'd1;
          end
        end

        shim_pkg::CONFIRM_SPI_START: begin
          if (!spi_off) begin // SPI up
            state               <= shim_pkg::POWER_ON_AMP_BRD;
            timer               <= '0;
            ctrl.n_shutdown_rst <= 1'b0; // Start of reset pulse
          end else if (boot_fault) begin
            state  <= shim_pkg::HALTING;
            status <= boot_status;
          end else if (timer >= SPI_START_WAIT) begin
            state  <= shim_pkg::HALTING;
            status <= '{board_num: '0, code: shim_pkg::SPI_START_TIMEOUT};
          end else begin
            timer <= timer + 32'd1;
          end
        end

        shim_pkg::POWER_ON_AMP_BRD: begin
          if (timer >= RST_PULSE) begin
            state               <= shim_pkg::AMP_POWER_WAIT;
            timer               <= '0;
            ctrl.n_shutdown_rst <= 1'b1; // End of pulse
          end else begin
            timer <= timer + 32'd1;
          end
        end

        shim_pkg::AMP_POWER_WAIT: begin
          if (timer >= RST_DELAY) begin
            state              <= shim_pkg::RUNNING;
            timer              <= '0;
            ctrl.block_buffers <= 1'b0; // Open buffers
            ps_interrupt       <= 1'b1; // Announce RUNNING
          end else begin
            timer <= timer + 32'd1;
          end
        end

        // Faults are masked while the entry interrupt is high
        shim_pkg::RUNNING: begin
          if (ps_interrupt) begin
            ps_interrupt <= 1'b0;
          end else if (run_fault) begin
            state  <= shim_pkg::HALTING;
            status <= run_status;
          end
        end

        shim_pkg::HALTING: begin
          state        <= shim_pkg::HALTED;
          timer        <= '0;
          ctrl         <= CTRL_OFF;
          ps_interrupt <= 1'b1;
        end

        // Status held until the host drops sys_en
        shim_pkg::HALTED: begin
          ps_interrupt <= 1'b0;
          if (!sys_en) begin
            state  <= shim_pkg::IDLE;
            status <= STATUS_OK;
          end
        end

        default: begin
          // Illegal state, shut down and flag it
          state        <= shim_pkg::HALTED;
          timer        <= '0;
          ctrl         <= CTRL_OFF;
          status       <= '{board_num: '0, code: shim_pkg::EMPTY};
          ps_interrupt <= 1'b1;
        end
      endcase
    end
  end

endmodule

// File: tb/shim_hw_manager_tb.sv
`timescale 1ns/10ps

module shim_hw_manager_tb;

  localparam int DELAY_SUM = 20 + 5 + 20 + 40 + 60; // Sum of the DUT delays below
  localparam int N_CFG = 6;
  localparam int N_BOOT = 6;
  localparam int N_RUN = 12;
  localparam int N_RUNS = 3 + N_CFG + N_BOOT + N_RUN; // Clean run and two timeouts
  localparam int PH_CFG = 0, PH_BOOT = 1, PH_RUN = 2;
  localparam int SPI_NORMAL = 0, SPI_STUCK_ON = 1, SPI_NEVER_UP = 2;

  // {unlock_cfg, spi_clk_gate, spi_en, sense_en, block_buffers, n_force, n_rst}
  localparam shim_pkg::shim_ctrl_t   CTRL_RESET = 7'b1000101;
  localparam shim_pkg::shim_ctrl_t   CTRL_RUN   = 7'b0111011;
  localparam shim_pkg::shim_status_t STATUS_OK  = {3'd0, shim_pkg::OK};

  logic clk, aresetn, sys_en, spi_off, lock_viol, ext_shutdown;
  shim_pkg::shim_cfg_flags_t   cfg;
  shim_pkg::shim_boot_flags_t  boot;
  shim_pkg::shim_board_flags_t board;
  shim_pkg::shim_ctrl_t        ctrl;
  logic [31:0]                 status_word;
  logic                        ps_interrupt;
  shim_pkg::shim_state_e       cur_state;
  shim_pkg::shim_state_e       prev_state = shim_pkg::IDLE;
  shim_pkg::shim_status_t      cur_status;
  shim_pkg::shim_status_t      exp_status = {3'd0, shim_pkg::OK};
  logic                        irq_q = 1'b0;
  logic                        spi_en_q = 1'b0;
  int                          spi_mode = 0;
  int                          spi_cnt = 0;
  int                          errors = 0;
  int                          halts = 0;

  assign cur_state  = shim_pkg::shim_state_e'(status_word[3:0]);
  assign cur_status = status_word[31:4];

  shim_hw_manager #(
    .FORCE_DELAY(20), .RST_PULSE(5), .RST_DELAY(20), .SPI_RST_WAIT(40), .SPI_START_WAIT(60)
  ) i_shim_hw_manager (.*);

  always #10 clk = ~clk; // 20 ns period

  // Lowest set board, 0 for an empty vector
  function automatic logic [2:0] lowest_bit(input logic [7:0] v);
    int n;
    n = 0;
    while (n < 7 && !v[n]) n++;
    return (v == 8'd0) ? 3'd0 : n[2:0];
  endfunction

  // Reference priority model for one phase, from the current flag inputs
  function automatic shim_pkg::shim_status_t expected_status(input int phase);
    shim_pkg::shim_code_e run_codes [9] = '{shim_pkg::OVER_THRESH, shim_pkg::THRESH_UNDERFLOW,
      shim_pkg::THRESH_OVERFLOW, shim_pkg::BAD_DAC_CMD, shim_pkg::DAC_BUF_UNDERFLOW,
      shim_pkg::DAC_BUF_OVERFLOW, shim_pkg::BAD_ADC_CMD, shim_pkg::ADC_CMD_BUF_UNDERFLOW,
      shim_pkg::ADC_CMD_BUF_OVERFLOW};
    shim_pkg::shim_status_t s;
    logic [7:0]             vec;
    s = STATUS_OK;
    case (phase)
      PH_CFG: begin
        casez (cfg) // Board always 0
          4'b1???: s.code = shim_pkg::INTEG_THRESH_AVG_OOB;
          4'b01??: s.code = shim_pkg::INTEG_WINDOW_OOB;
          4'b001?: s.code = shim_pkg::INTEG_EN_OOB;
          4'b0001: s.code = shim_pkg::SYS_EN_OOB;
          default: s.code = shim_pkg::OK;
        endcase
      end
      PH_BOOT: begin
        if (boot.dac_boot_fail != 8'd0) begin // DAC over ADC
          s = {lowest_bit(boot.dac_boot_fail), shim_pkg::DAC_BOOT_FAIL};
        end else begin
          s = {lowest_bit(boot.adc_boot_fail), shim_pkg::ADC_BOOT_FAIL};
        end
      end
      default: begin
        if (!sys_en) s.code = shim_pkg::PS_SHUTDOWN;
        else if (lock_viol) s.code = shim_pkg::LOCK_VIOL;
        else if (board.shutdown_sense != 8'd0) begin
          s = {lowest_bit(board.shutdown_sense), shim_pkg::SHUTDOWN_SENSE};
        end else if (ext_shutdown) s.code = shim_pkg::EXT_SHUTDOWN;
        else begin
          for (int k = 8; k >= 0; k--) begin // Highest priority written last
            vec = board[71 - 8 * k -: 8];
            if (vec != 8'd0) s = {lowest_bit(vec), run_codes[k]};
          end
        end
      end
    endcase
    return s;
  endfunction

  task automatic check_status(input shim_pkg::shim_status_t got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s status board %0d code %h, expected board %0d code %h",
               $time, what, got.board_num, got.code, exp.board_num, exp.code);
    end
  endtask

  task automatic check_state(input shim_pkg::shim_state_e got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s state %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_ctrl(input shim_pkg::shim_ctrl_t got, exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s ctrl %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Step on falling edges until the state shows up, one full run at most
  task automatic wait_state(input shim_pkg::shim_state_e target);
    int n;
    n = 0;
    while (cur_state != target && n < DELAY_SUM + 100) begin
      @(negedge clk);
      n++;
    end
    if (cur_state != target) begin
      errors++;
      $display("Timed out at %0t waiting for state %0d, DUT in %0d", $time, target, cur_state);
    end
  endtask

  task automatic clear_flags();
    lock_viol    = 1'b0;
    ext_shutdown = 1'b0;
    cfg          = '0;
    boot         = '0;
    board        = '0;
    spi_mode     = SPI_NORMAL;
  endtask

  // From HALTED back to IDLE
  task automatic shut_down();
    sys_en = 1'b0;
    clear_flags();
    wait_state(shim_pkg::IDLE);
    @(negedge clk);
  endtask

  // SPI subsystem, starts a random 1 to 30 cycles after spi_en
  always @(negedge clk) begin : spi_model
    if (spi_mode == SPI_STUCK_ON) begin
      spi_off = 1'b0;
    end else if (!aresetn || !ctrl.spi_en) begin
      spi_off = 1'b1;
    end else if (spi_mode == SPI_NORMAL) begin
      if (!spi_en_q) spi_cnt = $urandom % 30 + 1; // spi_en just rose
      else if (spi_cnt > 0) spi_cnt--;
      if (spi_cnt == 0) spi_off = 1'b0;
    end
    spi_en_q = aresetn && ctrl.spi_en;
  end

  // Halt status, entry pulses and pulse width
  always @(negedge clk) begin : compare
    if (aresetn) begin
      if (cur_state != prev_state && !ps_interrupt &&
          (cur_state == shim_pkg::HALTED || cur_state == shim_pkg::RUNNING)) begin
        errors++;
        $display("[ERROR] %0t: no interrupt on entry to state %0d", $time, cur_state);
      end
      if (ps_interrupt && irq_q) begin
        errors++;
        $display("[ERROR] %0t: ps_interrupt high for more than one cycle", $time);
      end
      if (cur_state == shim_pkg::HALTED && prev_state != shim_pkg::HALTED) begin
        halts++;
        check_status(cur_status, exp_status, "halt");
      end
    end
    prev_state = cur_state;
    irq_q      = ps_interrupt;
  end

  initial begin : stimulus
    int pick;
    void'($urandom(48473));
    clk     = 1'b0;
    aresetn = 1'b0;
    sys_en  = 1'b0;
    spi_off = 1'b1;
    clear_flags();
    repeat (10) @(negedge clk);
    aresetn = 1'b1;
    @(negedge clk);
    check_state(cur_state, shim_pkg::IDLE, "reset");
    check_status(cur_status, STATUS_OK, "reset");
    check_ctrl(ctrl, CTRL_RESET, "reset");
    if (ps_interrupt !== 1'b0) begin
      errors++;
      $display("[ERROR] %0t: ps_interrupt %b after reset", $time, ps_interrupt);
    end

    // Clean power-up, then orderly shutdown
    sys_en = 1'b1;
    wait_state(shim_pkg::RUNNING);
    check_ctrl(ctrl, CTRL_RUN, "running");
    sys_en     = 1'b0;
    exp_status = expected_status(PH_RUN);
    wait_state(shim_pkg::HALTED);
    check_ctrl(ctrl, CTRL_RESET, "halted");
    wait_state(shim_pkg::IDLE);
    check_status(cur_status, STATUS_OK, "idle");

    repeat (N_CFG) begin // Range checks
      @(negedge clk);
      cfg        = 4'($urandom % 15 + 1);
      sys_en     = 1'b1;
      exp_status = expected_status(PH_CFG);
      wait_state(shim_pkg::HALTED);
      shut_down();
    end

    repeat (N_BOOT) begin // Boot failures while SPI is starting
      spi_mode = SPI_NEVER_UP;
      @(negedge clk);
      sys_en = 1'b1;
      wait_state(shim_pkg::CONFIRM_SPI_START);
      boot.dac_boot_fail = ($urandom % 2 == 1) ? 8'($urandom) : 8'd0;
      boot.adc_boot_fail = 8'($urandom % 255 + 1);
      exp_status = expected_status(PH_BOOT);
      wait_state(shim_pkg::HALTED);
      shut_down();
    end

    repeat (N_RUN) begin // One to three running faults
      sys_en = 1'b1;
      wait_state(shim_pkg::RUNNING);
      repeat ($urandom % 3 + 1) begin
        pick = $urandom % 12;
        if (pick == 10) lock_viol = 1'b1;
        else if (pick == 11) ext_shutdown = 1'b1;
        else board[79 - 8 * pick -: 8] = 8'($urandom % 255 + 1);
      end
      exp_status = expected_status(PH_RUN);
      wait_state(shim_pkg::HALTED);
      shut_down();
    end

    spi_mode = SPI_STUCK_ON; // SPI never reports off
    @(negedge clk);
    sys_en     = 1'b1;
    exp_status = {3'd0, shim_pkg::SPI_RESET_TIMEOUT};
    wait_state(shim_pkg::HALTED);
    shut_down();
    spi_mode = SPI_NEVER_UP; // SPI never starts
    @(negedge clk);
    sys_en     = 1'b1;
    exp_status = {3'd0, shim_pkg::SPI_START_TIMEOUT};
    wait_state(shim_pkg::HALTED);
    shut_down();

    if (halts != N_RUNS) begin
      errors++;
      $display("Saw %0d halts but %0d runs were started", halts, N_RUNS);
    end
    $display("Run complete with %0d errors over %0d halts", errors, halts);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(N_RUNS * (DELAY_SUM + 100) * 20);
    $display("Watchdog expired at %0t, the DUT stopped making progress", $time);
    $display("test failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+hdl
hdl/shim_pkg.sv
hdl/shim_fault_arbiter.sv
hdl/shim_power_sequencer.sv
hdl/shim_hw_manager.sv
tb/shim_hw_manager_tb.sv
